/* src/axi_pkg.sv */
package axi_pkg;

  // ---------------------------------------------------------------------------
  // bus widths
  // ---------------------------------------------------------------------------
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 64;
  localparam int unsigned ID_WIDTH   = 4;

  typedef logic [ADDR_WIDTH-1:0]   addr_t;
  typedef logic [DATA_WIDTH-1:0]   data_t;
  typedef logic [DATA_WIDTH/8-1:0] strb_t;
  typedef logic [ID_WIDTH-1:0]     id_t;

  // burst length minus one
  typedef logic [7:0] len_t;
  // log2 of bytes per beat
  typedef logic [2:0] size_t;
  typedef logic [1:0] burst_t;
  typedef logic [1:0] resp_t;

  // ---------------------------------------------------------------------------
  // channel payloads, valid and ready travel beside them
  // ---------------------------------------------------------------------------
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  // read address carries the same fields as the write address
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
  } ar_chan_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
  } r_chan_t;

endpackage

/* src/adapter_pkg.sv */
package adapter_pkg;

  // ---------------------------------------------------------------------------
  // cache side request kinds
  // ---------------------------------------------------------------------------
  // a single beat, or a whole cache line as an incrementing burst
  typedef enum logic {
    SINGLE_REQ = 1'b0,
    LINE_REQ   = 1'b1
  } req_type_e;

  // ---------------------------------------------------------------------------
  // bus encodings used by the engines
  // ---------------------------------------------------------------------------
  localparam axi_pkg::burst_t BURST_INCR = 2'b01;

  // line bursts always move full bus beats
  localparam axi_pkg::size_t SIZE_BEAT = axi_pkg::size_t'($clog2(axi_pkg::DATA_WIDTH / 8));

  // ---------------------------------------------------------------------------
  // engine state machines
  // ---------------------------------------------------------------------------
  // write path, AW and W may complete in either order
  typedef enum logic [2:0] {
    WR_IDLE,
    WR_WAIT_AW_W,
    WR_WAIT_W,
    WR_WAIT_AW,
    WR_WAIT_B
  } wr_state_e;

  // read path, COMPLETE hands the line back one cycle after the last beat
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_WAIT_R,
    RD_COMPLETE
  } rd_state_e;

endpackage

/* src/axi_write_engine.sv */
`timescale 1ns/100ps

module axi_write_engine #(
  parameter int unsigned LINE_BEATS = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // cache side
  input  logic                                  req_i,
  input  adapter_pkg::req_type_e                type_i,
  input  axi_pkg::addr_t                        addr_i,
  input  axi_pkg::size_t                        size_i,
  input  axi_pkg::id_t                          id_i,
  input  axi_pkg::data_t [LINE_BEATS-1:0]       wdata_i,
  input  axi_pkg::strb_t [LINE_BEATS-1:0]       be_i,
  output logic                                  gnt_o,
  output logic                                  valid_o,
  output logic                                  busy_o,
  output axi_pkg::id_t                          id_o,
  // write address and data
  output logic                                  aw_valid_o,
  output axi_pkg::aw_chan_t                     aw_o,
  input  logic                                  aw_ready_i,
  output logic                                  w_valid_o,
  output axi_pkg::w_chan_t                      w_o,
  input  logic                                  w_ready_i,
  // write response
  input  logic                                  b_valid_i,
  input  axi_pkg::b_chan_t                      b_i,
  output logic                                  b_ready_o
);

  localparam int unsigned CNT_W      = (LINE_BEATS > 1) ? $clog2(LINE_BEATS) : 1;
  localparam int unsigned LINE_BYTES = (axi_pkg::DATA_WIDTH / 8) * LINE_BEATS;

  typedef logic [CNT_W-1:0] beat_idx_t;

  localparam beat_idx_t      LAST_BEAT = beat_idx_t'(LINE_BEATS - 1);
  localparam axi_pkg::addr_t LINE_MASK = axi_pkg::addr_t'(LINE_BYTES - 1);

  adapter_pkg::wr_state_e state_q, state_d;
  beat_idx_t              cnt_q, cnt_d;

  logic      is_line;
  logic      aw_pend;
  logic      w_pend;
  logic      w_last;
  logic      aw_left;
  logic      w_left;
  beat_idx_t beat_idx;

  assign is_line = (type_i == adapter_pkg::LINE_REQ);

  // ---------------------------------------------------------------------------
  // channel payloads
  // ---------------------------------------------------------------------------
  // request inputs are held until gnt, so AW and W are taken straight from them
  assign aw_o.id    = id_i;
  assign aw_o.addr  = is_line ? (addr_i & ~LINE_MASK) : addr_i;
  assign aw_o.len   = is_line ? axi_pkg::len_t'(LINE_BEATS - 1) : '0;
  assign aw_o.size  = is_line ? adapter_pkg::SIZE_BEAT : size_i;
  assign aw_o.burst = adapter_pkg::BURST_INCR;

  // single writes always use element 0
  assign beat_idx = is_line ? cnt_q : '0;
  assign w_last   = !is_line || (cnt_q == LAST_BEAT);

  assign w_o.data = wdata_i[beat_idx];
  assign w_o.strb = be_i[beat_idx];
  assign w_o.last = w_last;

  // which channels still have something to send in this state
  always_comb begin
    aw_pend = 1'b0;
    w_pend  = 1'b0;
    case (state_q)
      adapter_pkg::WR_IDLE: begin
        aw_pend = req_i;
        w_pend  = req_i;
      end
      adapter_pkg::WR_WAIT_AW_W: begin
        aw_pend = 1'b1;
        w_pend  = 1'b1;
      end
      adapter_pkg::WR_WAIT_AW: begin
        aw_pend = 1'b1;
      end
      adapter_pkg::WR_WAIT_W: begin
        w_pend = 1'b1;
      end
      default: ;
    endcase
  end

  assign aw_valid_o = aw_pend;
  assign w_valid_o  = w_pend;

  // still outstanding after this cycle
  assign aw_left = aw_pend && !aw_ready_i;
  assign w_left  = w_pend && !(w_ready_i && w_last);

  // ---------------------------------------------------------------------------
  // next state
  // ---------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    gnt_o   = 1'b0;
    valid_o = 1'b0;

    if (state_q == adapter_pkg::WR_WAIT_B) begin
      if (b_valid_i) begin
        valid_o = 1'b1;
        state_d = adapter_pkg::WR_IDLE;
      end
    end else if (aw_pend || w_pend) begin
      // one beat per W handshake, wrap to zero after the last one
      if (w_pend && w_ready_i) begin
        cnt_d = w_last ? '0 : cnt_q + 1'b1;
      end
      case ({aw_left, w_left})
        2'b11: state_d = adapter_pkg::WR_WAIT_AW_W;
        2'b10: state_d = adapter_pkg::WR_WAIT_AW;
        2'b01: state_d = adapter_pkg::WR_WAIT_W;
        default: begin
          // address and all data accepted
          gnt_o   = 1'b1;
          state_d = adapter_pkg::WR_WAIT_B;
        end
      endcase
    end
  end

  assign b_ready_o = (state_q == adapter_pkg::WR_WAIT_B);
  assign id_o      = b_i.id;
  assign busy_o    = (state_q != adapter_pkg::WR_IDLE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= adapter_pkg::WR_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

endmodule

/* src/axi_read_engine.sv */
`timescale 1ns/100ps

module axi_read_engine #(
  parameter int unsigned LINE_BEATS = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // cache side
  input  logic                                  req_i,
  input  adapter_pkg::req_type_e                type_i,
  input  axi_pkg::addr_t                        addr_i,
  input  axi_pkg::size_t                        size_i,
  input  axi_pkg::id_t                          id_i,
  output logic                                  gnt_o,
  output logic                                  valid_o,
  output logic                                  busy_o,
  output axi_pkg::id_t                          id_o,
  output axi_pkg::data_t [LINE_BEATS-1:0]       rdata_o,
  output axi_pkg::data_t                        critical_word_o,
  output logic                                  critical_word_valid_o,
  // read address
  output logic                                  ar_valid_o,
  output axi_pkg::ar_chan_t                     ar_o,
  input  logic                                  ar_ready_i,
  // read data
  input  logic                                  r_valid_i,
  input  axi_pkg::r_chan_t                      r_i,
  output logic                                  r_ready_o
);

  localparam int unsigned CNT_W      = (LINE_BEATS > 1) ? $clog2(LINE_BEATS) : 1;
  localparam int unsigned BYTE_W     = $clog2(axi_pkg::DATA_WIDTH / 8);
  localparam int unsigned LINE_BYTES = (axi_pkg::DATA_WIDTH / 8) * LINE_BEATS;

  typedef logic [CNT_W-1:0] beat_idx_t;

  localparam axi_pkg::addr_t LINE_MASK = axi_pkg::addr_t'(LINE_BYTES - 1);

  adapter_pkg::rd_state_e state_q, state_d;
  beat_idx_t              cnt_q;
  // word within the line that the cache asked for
  beat_idx_t              offset_q;
  logic                   line_q;
  axi_pkg::id_t           id_q;
  axi_pkg::data_t [LINE_BEATS-1:0] line_buf_q;

  logic      is_line;
  logic      ar_hs;
  logic      r_hs;
  beat_idx_t wr_idx;

  assign is_line = (type_i == adapter_pkg::LINE_REQ);

  // ---------------------------------------------------------------------------
  // read address
  // ---------------------------------------------------------------------------
  // line fetches always start at the line base
  assign ar_o.id    = id_i;
  assign ar_o.addr  = is_line ? (addr_i & ~LINE_MASK) : addr_i;
  assign ar_o.len   = is_line ? axi_pkg::len_t'(LINE_BEATS - 1) : '0;
  assign ar_o.size  = is_line ? adapter_pkg::SIZE_BEAT : size_i;
  assign ar_o.burst = adapter_pkg::BURST_INCR;

  assign ar_valid_o = (state_q == adapter_pkg::RD_IDLE) && req_i;
  assign ar_hs      = ar_valid_o && ar_ready_i;
  assign gnt_o      = ar_hs;

  // ---------------------------------------------------------------------------
  // read data
  // ---------------------------------------------------------------------------
  assign r_ready_o = (state_q == adapter_pkg::RD_WAIT_R);
  assign r_hs      = r_ready_o && r_valid_i;

  // single reads land in element 0
  assign wr_idx = line_q ? cnt_q : '0;

  // critical word goes out in the same cycle its beat arrives
  assign critical_word_o       = r_i.data;
  assign critical_word_valid_o = r_hs && line_q && (cnt_q == offset_q);

  always_comb begin
    state_d = state_q;
    case (state_q)
      adapter_pkg::RD_IDLE: begin
        if (ar_hs) begin
          state_d = adapter_pkg::RD_WAIT_R;
        end
      end
      adapter_pkg::RD_WAIT_R: begin
        if (r_hs && r_i.last) begin
          state_d = adapter_pkg::RD_COMPLETE;
        end
      end
      adapter_pkg::RD_COMPLETE: begin
        state_d = adapter_pkg::RD_IDLE;
      end
      default: state_d = adapter_pkg::RD_IDLE;
    endcase
  end

  assign valid_o = (state_q == adapter_pkg::RD_COMPLETE);
  assign id_o    = id_q;
  assign rdata_o = line_buf_q;
  assign busy_o  = (state_q != adapter_pkg::RD_IDLE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= adapter_pkg::RD_IDLE;
      cnt_q    <= '0;
      offset_q <= '0;
      line_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (ar_hs) begin
        cnt_q    <= '0;
        line_q   <= is_line;
        offset_q <= addr_i[BYTE_W +: CNT_W];
      end else if (r_hs) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // line buffer and returned id
  always_ff @(posedge clk_i) begin
    if (r_hs) begin
      line_buf_q[wr_idx] <= r_i.data;
      if (r_i.last) begin
        id_q <= r_i.id;
      end
    end
  end

endmodule

/* src/axi_adapter.sv */
`timescale 1ns/100ps

module axi_adapter #(
  parameter int unsigned LINE_BEATS = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // cache side
  input  logic                                  req_i,
  input  logic                                  we_i,
  input  adapter_pkg::req_type_e                type_i,
  input  axi_pkg::addr_t                        addr_i,
  input  axi_pkg::size_t                        size_i,
  input  axi_pkg::id_t                          id_i,
  input  axi_pkg::data_t [LINE_BEATS-1:0]       wdata_i,
  input  axi_pkg::strb_t [LINE_BEATS-1:0]       be_i,
  output logic                                  gnt_o,
  output logic                                  busy_o,
  output logic                                  valid_o,
  output axi_pkg::id_t                          id_o,
  output axi_pkg::data_t [LINE_BEATS-1:0]       rdata_o,
  output axi_pkg::data_t                        critical_word_o,
  output logic                                  critical_word_valid_o,
  // AXI master port
  output logic                                  aw_valid_o,
  output axi_pkg::aw_chan_t                     aw_o,
  input  logic                                  aw_ready_i,
  output logic                                  w_valid_o,
  output axi_pkg::w_chan_t                      w_o,
  input  logic                                  w_ready_i,
  input  logic                                  b_valid_i,
  input  axi_pkg::b_chan_t                      b_i,
  output logic                                  b_ready_o,
  output logic                                  ar_valid_o,
  output axi_pkg::ar_chan_t                     ar_o,
  input  logic                                  ar_ready_i,
  input  logic                                  r_valid_i,
  input  axi_pkg::r_chan_t                      r_i,
  output logic                                  r_ready_o
);

  logic         wr_req, rd_req;
  logic         wr_gnt, rd_gnt;
  logic         wr_valid, rd_valid;
  logic         wr_busy, rd_busy;
  axi_pkg::id_t wr_id, rd_id;

  // writes and reads go to separate engines, only one is active at a time
  assign wr_req = req_i && we_i;
  assign rd_req = req_i && !we_i;

  axi_write_engine #(
    .LINE_BEATS (LINE_BEATS)
  ) i_write_engine (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (wr_req),
    .type_i     (type_i),
    .addr_i     (addr_i),
    .size_i     (size_i),
    .id_i       (id_i),
    .wdata_i    (wdata_i),
    .be_i       (be_i),
    .gnt_o      (wr_gnt),
    .valid_o    (wr_valid),
    .busy_o     (wr_busy),
    .id_o       (wr_id),
    .aw_valid_o (aw_valid_o),
    .aw_o       (aw_o),
    .aw_ready_i (aw_ready_i),
    .w_valid_o  (w_valid_o),
    .w_o        (w_o),
    .w_ready_i  (w_ready_i),
    .b_valid_i  (b_valid_i),
    .b_i        (b_i),
    .b_ready_o  (b_ready_o)
  );

  axi_read_engine #(
    .LINE_BEATS (LINE_BEATS)
  ) i_read_engine (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .req_i                 (rd_req),
    .type_i                (type_i),
    .addr_i                (addr_i),
    .size_i                (size_i),
    .id_i                  (id_i),
    .gnt_o                 (rd_gnt),
    .valid_o               (rd_valid),
    .busy_o                (rd_busy),
    .id_o                  (rd_id),
    .rdata_o               (rdata_o),
    .critical_word_o       (critical_word_o),
    .critical_word_valid_o (critical_word_valid_o),
    .ar_valid_o            (ar_valid_o),
    .ar_o                  (ar_o),
    .ar_ready_i            (ar_ready_i),
    .r_valid_i             (r_valid_i),
    .r_i                   (r_i),
    .r_ready_o             (r_ready_o)
  );

  // merge the cache side returns
  assign gnt_o   = wr_gnt || rd_gnt;
  assign valid_o = wr_valid || rd_valid;
  assign busy_o  = wr_busy || rd_busy;
  assign id_o    = wr_valid ? wr_id : rd_id;

endmodule

/* tb/axi_mem_model.sv */
`timescale 1ns/100ps

module axi_mem_model #(
  parameter int unsigned    LINE_BEATS = 4,
  parameter axi_pkg::data_t INIT_KEY   = '0
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               aw_valid_i,
  input  axi_pkg::aw_chan_t  aw_i,
  output logic               aw_ready_o,
  input  logic               w_valid_i,
  input  axi_pkg::w_chan_t   w_i,
  output logic               w_ready_o,
  output logic               b_valid_o,
  output axi_pkg::b_chan_t   b_o,
  input  logic               b_ready_i,
  input  logic               ar_valid_i,
  input  axi_pkg::ar_chan_t  ar_i,
  output logic               ar_ready_o,
  output logic               r_valid_o,
  output axi_pkg::r_chan_t   r_o,
  input  logic               r_ready_i,
  output logic               error_o
);

  localparam int unsigned LINE_BYTES = (axi_pkg::DATA_WIDTH / 8) * LINE_BEATS;

  axi_pkg::data_t    mem [axi_pkg::addr_t];
  axi_pkg::aw_chan_t aw_q [$];
  axi_pkg::w_chan_t  w_q [$];
  axi_pkg::id_t      b_q [$];
  axi_pkg::ar_chan_t ar_q [$];
  int unsigned       r_beat;
  logic              aw_wait, w_wait, ar_wait;
  axi_pkg::aw_chan_t aw_hold, ar_hold;
  axi_pkg::w_chan_t  w_hold;

  function automatic axi_pkg::data_t load_word(axi_pkg::addr_t addr);
    axi_pkg::addr_t waddr;
    waddr = addr >> 3;
    if (mem.exists(waddr)) return mem[waddr];
    return {32'h0, waddr} ^ INIT_KEY;
  endfunction

  task automatic flag_error(string msg);
    $display("protocol error: %s", msg);
    error_o = 1'b1;
  endtask

  // burst format shared by AW and AR
  task automatic check_burst(string ch, axi_pkg::aw_chan_t a);
    if (a.len != 0 && a.len != axi_pkg::len_t'(LINE_BEATS - 1))
      flag_error($sformatf("%s length %0d is neither single nor a full line", ch, a.len));
    if (a.len != 0 && (a.addr & axi_pkg::addr_t'(LINE_BYTES - 1)) != 0)
      flag_error($sformatf("%s line burst address %h is not line aligned", ch, a.addr));
    if (a.size != axi_pkg::size_t'(3))
      flag_error($sformatf("%s size %0d does not move a full 8-byte beat", ch, a.size));
    if (a.burst != adapter_pkg::BURST_INCR)
      flag_error($sformatf("%s burst kind is not incrementing", ch));
  endtask

  // apply a write once its address and every data beat have arrived
  task automatic commit_writes();
    axi_pkg::aw_chan_t a;
    axi_pkg::w_chan_t  w;
    axi_pkg::addr_t    waddr;
    while (aw_q.size() > 0 && w_q.size() >= int'(aw_q[0].len) + 1) begin
      a = aw_q.pop_front();
      for (int i = 0; i <= int'(a.len); i++) begin
        w = w_q.pop_front();
        if (w.last != (i == int'(a.len)))
          flag_error($sformatf("W last flag wrong on beat %0d of %0d", i, a.len + 1));
        waddr = (a.addr >> 3) + axi_pkg::addr_t'(i);
        mem[waddr] = load_word(waddr << 3);
        for (int b = 0; b < axi_pkg::DATA_WIDTH / 8; b++) begin
          if (w.strb[b]) mem[waddr][b*8 +: 8] = w.data[b*8 +: 8];
        end
      end
      b_q.push_back(a.id);
    end
  endtask

  initial begin
    error_o    = 1'b0;
    aw_ready_o = 1'b0;
    w_ready_o  = 1'b0;
    ar_ready_o = 1'b0;
    b_valid_o  = 1'b0;
    r_valid_o  = 1'b0;
    b_o        = '0;
    r_o        = '0;
    r_beat     = 0;
    aw_wait    = 1'b0;
    w_wait     = 1'b0;
    ar_wait    = 1'b0;
  end

  always @(posedge clk_i) begin : model_step
    logic b_hs, r_hs;
    if (rst_ni) begin
      // ----------------------------------------------------------------------
      // sample the bus at the edge
      // ----------------------------------------------------------------------
      if (aw_wait && (!aw_valid_i || aw_i != aw_hold)) flag_error("AW dropped before ready");
      if (w_wait && (!w_valid_i || w_i != w_hold)) flag_error("W dropped before ready");
      if (ar_wait && (!ar_valid_i || axi_pkg::aw_chan_t'(ar_i) != ar_hold))
        flag_error("AR dropped before ready");
      aw_wait = aw_valid_i && !aw_ready_o;
      w_wait  = w_valid_i && !w_ready_o;
      ar_wait = ar_valid_i && !ar_ready_o;
      aw_hold = aw_i;
      w_hold  = w_i;
      ar_hold = axi_pkg::aw_chan_t'(ar_i);

      if (aw_valid_i && aw_ready_o) begin
        check_burst("AW", aw_i);
        aw_q.push_back(aw_i);
      end
      if (w_valid_i && w_ready_o) w_q.push_back(w_i);
      if (ar_valid_i && ar_ready_o) begin
        check_burst("AR", axi_pkg::aw_chan_t'(ar_i));
        ar_q.push_back(ar_i);
      end
      commit_writes();

      b_hs = b_valid_o && b_ready_i;
      if (b_hs) void'(b_q.pop_front());
      r_hs = r_valid_o && r_ready_i;
      if (r_hs) begin
        r_beat++;
        if (r_o.last) begin
          void'(ar_q.pop_front());
          r_beat = 0;
        end
      end

      // drive the next cycle just after the edge
      #2;
      aw_ready_o = ($urandom % 4) != 0;
      w_ready_o  = ($urandom % 4) != 0;
      ar_ready_o = ($urandom % 4) != 0;
      if (!b_valid_o || b_hs) begin
        b_valid_o = (b_q.size() > 0) && (($urandom % 3) != 0);
        b_o.id    = (b_q.size() > 0) ? b_q[0] : '0;
        b_o.resp  = '0;
      end
      if (!r_valid_o || r_hs) begin
        r_valid_o = (ar_q.size() > 0) && (($urandom % 3) != 0);
        r_o       = '0;
        if (ar_q.size() > 0) begin
          r_o.id   = ar_q[0].id;
          r_o.data = load_word(ar_q[0].addr + axi_pkg::addr_t'(r_beat * 8));
          r_o.last = (r_beat == int'(ar_q[0].len));
        end
      end
    end
  end

endmodule

/* tb/tb_axi_adapter.sv */
`timescale 1ns/100ps

module tb_axi_adapter;

  localparam int unsigned    LINE_BEATS = 4;
  localparam int unsigned    LINE_BYTES = 8 * LINE_BEATS;
  localparam axi_pkg::data_t INIT_KEY   = 64'h5a3c_96e1_0f0f_c3a5;
  localparam int unsigned    RAND_TXNS  = 24;
  // directed transactions plus the random ones
  localparam int unsigned    NUM_TXN    = 6 + RAND_TXNS;
  localparam int unsigned    MAX_CYCLES = 200 * NUM_TXN;

  typedef axi_pkg::data_t [LINE_BEATS-1:0] line_t;
  typedef axi_pkg::strb_t [LINE_BEATS-1:0] line_strb_t;

  logic clk_i, rst_ni;
  logic req_i, we_i;
  adapter_pkg::req_type_e type_i;
  axi_pkg::addr_t addr_i;
  axi_pkg::size_t size_i;
  axi_pkg::id_t   id_i, id_o;
  line_t          wdata_i, rdata_o;
  line_strb_t     be_i;
  logic gnt_o, busy_o, valid_o, critical_word_valid_o;
  axi_pkg::data_t critical_word_o;
  logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic ar_valid, ar_ready, r_valid, r_ready, mem_err;
  axi_pkg::aw_chan_t aw;
  axi_pkg::w_chan_t  w;
  axi_pkg::b_chan_t  b;
  axi_pkg::ar_chan_t ar;
  axi_pkg::r_chan_t  r;
  int unsigned cycles;
  // words written so far, keyed by word address
  axi_pkg::data_t shadow [axi_pkg::addr_t];

  axi_adapter #(.LINE_BEATS(LINE_BEATS)) axi_adapter_i (
    .clk_i, .rst_ni, .req_i, .we_i, .type_i, .addr_i, .size_i, .id_i, .wdata_i, .be_i,
    .gnt_o, .busy_o, .valid_o, .id_o, .rdata_o, .critical_word_o, .critical_word_valid_o,
    .aw_valid_o(aw_valid), .aw_o(aw), .aw_ready_i(aw_ready),
    .w_valid_o(w_valid), .w_o(w), .w_ready_i(w_ready),
    .b_valid_i(b_valid), .b_i(b), .b_ready_o(b_ready),
    .ar_valid_o(ar_valid), .ar_o(ar), .ar_ready_i(ar_ready),
    .r_valid_i(r_valid), .r_i(r), .r_ready_o(r_ready)
  );

  axi_mem_model #(.LINE_BEATS(LINE_BEATS), .INIT_KEY(INIT_KEY)) i_mem (
    .clk_i, .rst_ni,
    .aw_valid_i(aw_valid), .aw_i(aw), .aw_ready_o(aw_ready),
    .w_valid_i(w_valid), .w_i(w), .w_ready_o(w_ready),
    .b_valid_o(b_valid), .b_o(b), .b_ready_i(b_ready),
    .ar_valid_i(ar_valid), .ar_i(ar), .ar_ready_o(ar_ready),
    .r_valid_o(r_valid), .r_o(r), .r_ready_i(r_ready),
    .error_o(mem_err)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // expected word is the initial pattern unless a write landed there
  function automatic axi_pkg::data_t expected_word(axi_pkg::addr_t addr);
    axi_pkg::addr_t waddr;
    waddr = addr >> 3;
    if (shadow.exists(waddr)) return shadow[waddr];
    return {32'h0, waddr} ^ INIT_KEY;
  endfunction

  task automatic record_write(axi_pkg::addr_t addr, axi_pkg::data_t data, axi_pkg::strb_t strb);
    axi_pkg::data_t word;
    word = expected_word(addr);
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) word[i*8 +: 8] = data[i*8 +: 8];
    end
    shadow[addr >> 3] = word;
  endtask

  task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // ---------------------------------------------------------------------------
  // one request from raise to valid_o
  // ---------------------------------------------------------------------------
  task automatic run_txn(logic we, adapter_pkg::req_type_e kind, axi_pkg::addr_t addr,
                         axi_pkg::id_t id, line_t wdata, line_strb_t be);
    logic           granted;
    int             cw_cnt;
    axi_pkg::addr_t base;
    @(posedge clk_i);
    #2;
    req_i   = 1'b1;
    we_i    = we;
    type_i  = kind;
    addr_i  = addr;
    size_i  = 3'd3;
    id_i    = id;
    wdata_i = wdata;
    be_i    = be;
    granted = 1'b0;
    cw_cnt  = 0;
    forever begin
      @(posedge clk_i);
      if (granted) check_value("busy_o", busy_o, 1);
      if (critical_word_valid_o) begin
        cw_cnt++;
        check_value("critical_word_o", critical_word_o, expected_word(addr));
      end
      if (valid_o) break;
      if (gnt_o && !granted) begin
        granted = 1'b1;
        #2;
        req_i = 1'b0;
      end
    end
    check_value("gnt_o before valid_o", granted, 1);
    check_value("id_o", id_o, id);
    base = addr & ~axi_pkg::addr_t'(LINE_BYTES - 1);
    if (we) begin
      if (kind == adapter_pkg::LINE_REQ) begin
        for (int i = 0; i < LINE_BEATS; i++) record_write(base + 8 * i, wdata[i], be[i]);
      end else begin
        record_write(addr, wdata[0], be[0]);
      end
    end else if (kind == adapter_pkg::LINE_REQ) begin
      check_value("critical_word_valid_o count", cw_cnt, 1);
      for (int i = 0; i < LINE_BEATS; i++)
        check_value($sformatf("rdata_o[%0d]", i), rdata_o[i], expected_word(base + 8 * i));
    end else begin
      check_value("critical_word_valid_o count", cw_cnt, 0);
      check_value("rdata_o[0]", rdata_o[0], expected_word(addr));
    end
  endtask

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the transactions did not finish within %0d cycles", MAX_CYCLES);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  // the model raises its error flag at the rising edge
  always @(negedge clk_i) begin
    if (mem_err) begin
      $display("the memory model saw a bus protocol violation");
      $display("TESTS FAILED");
      $fatal(1, "protocol violation");
    end
  end

  initial begin
    line_t      data;
    line_strb_t strb;
    logic       we;
    adapter_pkg::req_type_e kind;
    void'($urandom(32'h2123_70e8));
    cycles  = 0;
    rst_ni  = 1'b0;
    req_i   = 1'b0;
    we_i    = 1'b0;
    type_i  = adapter_pkg::SINGLE_REQ;
    addr_i  = '0;
    size_i  = '0;
    id_i    = '0;
    wdata_i = '0;
    be_i    = '0;
    repeat (4) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(posedge clk_i);
    check_value("busy_o", busy_o, 0);
    check_value("gnt_o", gnt_o, 0);
    check_value("valid_o", valid_o, 0);
    check_value("critical_word_valid_o", critical_word_valid_o, 0);
    check_value("bus valid and ready", {aw_valid, w_valid, ar_valid, b_ready, r_ready}, 0);

    // single write with partial strobes, then read it back
    data = '0;
    data[0] = 64'hdead_beef_0123_4567;
    strb = '0;
    strb[0] = 8'b1010_0110;
    run_txn(1'b1, adapter_pkg::SINGLE_REQ, 32'h0000_1018, 4'h3, data, strb);
    run_txn(1'b0, adapter_pkg::SINGLE_REQ, 32'h0000_1018, 4'h5, '0, '0);

    // full line write, then line reads from inside the line
    for (int i = 0; i < LINE_BEATS; i++) begin
      data[i] = {$urandom, $urandom};
      strb[i] = 8'hff;
    end
    run_txn(1'b1, adapter_pkg::LINE_REQ, 32'h0000_1048, 4'h9, data, strb);
    run_txn(1'b0, adapter_pkg::LINE_REQ, 32'h0000_1048, 4'ha, '0, '0);
    run_txn(1'b0, adapter_pkg::LINE_REQ, 32'h0000_1058, 4'hb, '0, '0);
    // untouched line still holds the fill pattern
    run_txn(1'b0, adapter_pkg::LINE_REQ, 32'h0000_1290, 4'hc, '0, '0);

    for (int n = 0; n < RAND_TXNS; n++) begin
      for (int i = 0; i < LINE_BEATS; i++) begin
        data[i] = {$urandom, $urandom};
        strb[i] = axi_pkg::strb_t'($urandom);
      end
      we   = logic'($urandom % 2);
      kind = adapter_pkg::req_type_e'($urandom % 2);
      run_txn(we, kind, 32'h0000_1000 + 8 * ($urandom % 64), axi_pkg::id_t'($urandom),
              data, strb);
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* list.f */
src/axi_pkg.sv
src/adapter_pkg.sv
src/axi_write_engine.sv
src/axi_read_engine.sv
src/axi_adapter.sv
tb/axi_mem_model.sv
tb/tb_axi_adapter.sv

/* run.sh */
#!/bin/sh
# build and run the testbench, the exit status carries pass or fail
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_axi_adapter \
  -f list.f \
  -o sim_tb_axi_adapter

./obj_dir/sim_tb_axi_adapter
